// ==== alu_pkg.sv ====
// ----------------------------------------
// alu package
// operand, result, status and opcode types,
// register map and bus response codes
// ----------------------------------------

package alu_pkg;

    typedef logic [15:0] operand_t;  // one 16-bit operand

    // both operands, a in the upper half
    typedef struct packed {
        operand_t a;
        operand_t b;
    } in_t;

    // opcode as written to the control register
    typedef enum logic [3:0] {
        OR   = 4'd0,
        AND  = 4'd1,
        MULT = 4'd2,
        ROL  = 4'd3,
        ROR  = 4'd4,
        SHL  = 4'd5,
        SHR  = 4'd6,
        SUB  = 4'd7,
        ADD  = 4'd8,
        DIV  = 4'd9
    } control_e;

    localparam int unsigned OP_COUNT = 10;  // codes 10..15 are illegal

    // flag order matches status register bits 3..0
    typedef struct packed {
        logic zero;
        logic div0;
        logic overflow;
        logic sign;
    } status_t;

    typedef logic [31:0] result_t;  // full alu output

    // byte offsets in the register window
    localparam logic [4:0] REG_A      = 5'h00;  // r/w
    localparam logic [4:0] REG_B      = 5'h04;  // r/w
    localparam logic [4:0] REG_CTRL   = 5'h08;  // write issues
    localparam logic [4:0] REG_RESULT = 5'h0C;  // read only
    localparam logic [4:0] REG_STATUS = 5'h10;  // read only, done in bit 4

    // AXI4-Lite response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

// ==== alu_op_if.sv ====
// ----------------------------------------
// alu operation bus
// issue pulse plus operands and opcode,
// from the register decoder to execute
// ----------------------------------------
`timescale 1ns/1ns

interface alu_op_if;
    import alu_pkg::*;

    logic     issue;     // one cycle per legal ctrl write
    in_t      operands;  // held between issues
    control_e control;   // held between issues

    // register decoder side
    modport source (
        output issue,
        output operands,
        output control
    );

    // combinational execute unit
    modport exec (
        input operands,
        input control
    );

    // result capture stage
    modport sink (
        input issue
    );

endinterface

// ==== alu_axi_decode.sv ====
// ----------------------------------------
// alu register decoder
// AXI4-Lite slave with operand and control
// registers, issue pulse and readback mux
// ----------------------------------------
`timescale 1ns/1ns

module alu_axi_decode #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [ADDR_WIDTH-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output alu_pkg::axi_resp_e      bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [ADDR_WIDTH-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output alu_pkg::axi_resp_e      rresp,
    output logic                    rvalid,
    input  logic                    rready,
    alu_op_if.source                op,
    input  alu_pkg::result_t        result,
    input  alu_pkg::status_t        status,
    input  logic                    done
);
    import alu_pkg::*;

    operand_t    reg_a;
    operand_t    reg_b;
    control_e    reg_ctrl;   // last legal opcode
    logic        live;       // set the cycle after reset ends
    logic        wr_accept;
    logic        rd_accept;
    logic [4:0]  wr_offset;
    logic [4:0]  rd_offset;
    logic        op_legal;
    logic        wr_issue;
    axi_resp_e   wr_resp;
    logic [31:0] rd_word;
    axi_resp_e   rd_resp;

    assign wr_offset = awaddr[4:0];  // upper address bits alias
    assign rd_offset = araddr[4:0];

    // address and data taken together, one write outstanding
    assign wr_accept = live && awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign arready   = live && !rvalid;
    assign rd_accept = arvalid && arready;

    assign op_legal = (wdata < OP_COUNT);  // whole word must be a valid code

    // write offset decode
    always_comb begin
        wr_resp  = OKAY;
        wr_issue = 1'b0;
        case (wr_offset)
            REG_A, REG_B: wr_resp = OKAY;
            REG_CTRL: begin
                if (op_legal) begin
                    wr_issue = 1'b1;
                end else begin
                    wr_resp = SLVERR;  // bad opcode, nothing issued
                end
            end
            default: wr_resp = SLVERR;  // read-only or unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            live     <= 1'b0;
            reg_a    <= '0;
            reg_b    <= '0;
            reg_ctrl <= OR;
            bvalid   <= 1'b0;
            op.issue <= 1'b0;
        end else begin
            live     <= 1'b1;
            op.issue <= wr_accept && wr_issue;  // lines up with bvalid rising
            if (wr_accept) begin
                bvalid <= 1'b1;
                case (wr_offset)
                    REG_A: reg_a <= wdata[15:0];
                    REG_B: reg_b <= wdata[15:0];
                    REG_CTRL: begin
                        if (op_legal) begin
                            reg_ctrl <= control_e'(wdata[3:0]);
                        end
                    end
                    default: ;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
    end

    assign op.operands = {reg_a, reg_b};
    assign op.control  = reg_ctrl;

    // readback mux
    always_comb begin
        rd_resp = OKAY;
        case (rd_offset)
            REG_A:      rd_word = {16'b0, reg_a};
            REG_B:      rd_word = {16'b0, reg_b};
            REG_CTRL:   rd_word = {28'b0, reg_ctrl};
            REG_RESULT: rd_word = result;
            REG_STATUS: rd_word = {27'b0, done, status};
            default: begin
                rd_word = '0;
                rd_resp = SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // data sampled at acceptance, held until rready
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

// ==== alu.sv ====
// ----------------------------------------
// alu execute unit
// combinational 16-bit ALU, 32-bit result
// and zero, div0, overflow, sign flags
// ----------------------------------------
`timescale 1ns/1ns

module alu (
    alu_op_if.exec           op,
    output alu_pkg::result_t out,
    output alu_pkg::status_t stat
);
    import alu_pkg::*;

    operand_t           a;
    operand_t           b;
    logic [31:0]        rol_tmp;
    logic [31:0]        ror_tmp;
    logic signed [17:0] arith;    // add/sub with sign extension

    assign a = op.operands.a;
    assign b = op.operands.b;

    // rotates work on a doubled copy, amount is b mod 16
    assign rol_tmp = {a, a} << b[3:0];
    assign ror_tmp = {a, a} >> b[3:0];

    always_comb begin
        arith = '0;
        case (op.control)
            OR:   out = {16'b0, a | b};
            AND:  out = {16'b0, a & b};
            MULT: out = {16'b0, a} * {16'b0, b};  // full product
            ROL:  out = {16'b0, rol_tmp[31:16]};
            ROR:  out = {16'b0, ror_tmp[15:0]};
            SHL:  out = {16'b0, a << b};  // 16 or more clears
            SHR:  out = {16'b0, a >> b};
            SUB: begin
                arith = {{2{a[15]}}, a} - {{2{b[15]}}, b};
                out   = {16'b0, arith[15:0]};
            end
            ADD: begin
                arith = {{2{a[15]}}, a} + {{2{b[15]}}, b};
                out   = {16'b0, arith[15:0]};
            end
            DIV: begin
                if (b != 16'd0) begin
                    out = {a % b, a / b};  // remainder high, quotient low
                end else begin
                    out = '0;
                end
            end
            default: out = '0;  // never issued
        endcase
    end

    always_comb begin : flag_logic
        stat.zero = (out == '0);
        stat.div0 = (op.control == DIV) && (b == 16'd0);
        // signed overflow when bits 16 and 15 of the wide sum disagree
        if (op.control == ADD || op.control == SUB) begin
            stat.overflow = arith[16] ^ arith[15];
        end else begin
            stat.overflow = 1'b0;
        end
        if (op.control == MULT) begin
            stat.sign = out[31];
        end else begin
            stat.sign = out[15];
        end
    end

endmodule

// ==== alu_result.sv ====
// ----------------------------------------
// alu result stage
// captures result and flags on issue and
// keeps the done bit for readback
// ----------------------------------------
`timescale 1ns/1ns

module alu_result (
    input  logic             clk,
    input  logic             reset,
    alu_op_if.sink           op,
    input  alu_pkg::result_t out,
    input  alu_pkg::status_t stat,
    output alu_pkg::result_t result,
    output alu_pkg::status_t status,
    output logic             done
);

    logic done_q;  // set by the last capture

    // hold values so later operand writes do not disturb readback
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            status <= '0;
            done_q <= 1'b0;
        end else if (op.issue) begin
            result <= out;
            status <= stat;
            done_q <= 1'b1;
        end
    end

    // low while an operation is in flight
    assign done = done_q && !op.issue;

endmodule

// ==== alu_top.sv ====
// ----------------------------------------
// alu peripheral top
// AXI4-Lite register decoder, execute unit
// and result stage
// ----------------------------------------
`timescale 1ns/1ns

module alu_top #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output alu_pkg::axi_resp_e    bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output alu_pkg::axi_resp_e    rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    alu_op_if op_bus ();

    alu_pkg::result_t alu_out;    // combinational result
    alu_pkg::status_t alu_stat;
    alu_pkg::result_t result_q;   // captured for readback
    alu_pkg::status_t status_q;
    logic             done;

    alu_axi_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) decode0 (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .op      (op_bus.source),
        .result  (result_q),
        .status  (status_q),
        .done    (done)
    );

    alu alu0 (
        .op   (op_bus.exec),
        .out  (alu_out),
        .stat (alu_stat)
    );

    alu_result result0 (
        .clk    (clk),
        .reset  (reset),
        .op     (op_bus.sink),
        .out    (alu_out),
        .stat   (alu_stat),
        .result (result_q),
        .status (status_q),
        .done   (done)
    );

endmodule

// ==== tb_alu.sv ====
// ----------------------------------------
// alu peripheral testbench
// directed and random register accesses
// checked against a behavioral model
// ----------------------------------------
`timescale 1ns/1ns

module tb_alu;
    import alu_pkg::*;

    localparam int CYCLE_NS     = 40;
    localparam int TXN_BUDGET   = 20;   // cycles allowed per bus transaction
    localparam int RANDOM_OPS   = 200;
    localparam int DIRECTED_OPS = 17;   // opcode, divide and error tests
    localparam int TXN_COUNT    = 4 + 5 * (DIRECTED_OPS + RANDOM_OPS) + 20;

    logic        clk;
    logic        reset;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    axi_resp_e   bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_e   rresp;
    logic        rvalid;
    logic        rready;

    int     errors       = 0;
    int     test_start   = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    integer seed         = 32'hf280;

    alu_top #(.ADDR_WIDTH(8)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    initial begin
        #(TXN_COUNT * TXN_BUDGET * CYCLE_NS);
        $display("watchdog expired after %0d ns, run timed out",
                 TXN_COUNT * TXN_BUDGET * CYCLE_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input status_t exp_s, input logic exp_done,
                                input status_t act_s, input logic act_done);
        if (act_s !== exp_s) begin
            $display("FAIL status expected %h got %h", exp_s, act_s);
            errors++;
        end
        if (act_done !== exp_done) begin
            $display("FAIL done expected %h got %h", exp_done, act_done);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // behavioral model of the operation rules
    function automatic void model(input control_e code, input operand_t a, input operand_t b,
                                  output result_t r, output status_t s);
        logic [31:0] wide;
        logic [15:0] low;
        low = '0;
        r   = '0;
        s   = '0;
        case (code)
            OR:   low = a | b;
            AND:  low = a & b;
            MULT: r = a * b;
            ROL: begin
                wide = {16'h0, a} << (b % 16);
                low  = wide[15:0] | wide[31:16];  // wrap spilled bits
            end
            ROR: begin
                wide = {a, 16'h0} >> (b % 16);
                low  = wide[31:16] | wide[15:0];
            end
            SHL:  low = (b < 16) ? a << b : 16'h0;
            SHR:  low = (b < 16) ? a >> b : 16'h0;
            SUB: begin
                low        = a - b;
                s.overflow = (a[15] != b[15]) && (low[15] != a[15]);
            end
            ADD: begin
                low        = a + b;
                s.overflow = (a[15] == b[15]) && (low[15] != a[15]);
            end
            DIV: begin
                s.div0 = (b == 16'h0);
                if (b != 16'h0) r = {a % b, a / b};
            end
            default: low = '0;
        endcase
        if (code != MULT && code != DIV) r = {16'h0, low};
        s.zero = (r == '0);
        s.sign = (code == MULT) ? r[31] : r[15];
    endfunction

    // hold keeps bready low that many cycles after the response shows up
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input int hold, output axi_resp_e resp);
        int waited;
        waited = 0;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        #(CYCLE_NS / 4);  // ready settles while the inputs are steady
        check_ready("awready", 1'b1, awready);
        check_ready("wready", 1'b1, wready);
        do begin
            @(negedge clk);
            waited++;
        end while (!bvalid && waited < TXN_BUDGET);
        check_ready("awready", 1'b0, awready);  // no second accept while bvalid
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        if (!bvalid) begin
            $display("write to offset %h got no response", addr);
            errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            if (!bvalid) begin
                $display("write response to %h dropped while bready was low", addr);
                errors++;
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid) begin
            $display("write response to %h was given more than once", addr);
            errors++;
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, input int hold,
                            output logic [31:0] data, output axi_resp_e resp);
        int waited;
        waited = 0;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        #(CYCLE_NS / 4);
        check_ready("arready", 1'b1, arready);
        do begin
            @(negedge clk);
            waited++;
        end while (!rvalid && waited < TXN_BUDGET);
        check_ready("arready", 1'b0, arready);  // one read outstanding
        arvalid = 1'b0;
        araddr  = '0;  // address is free after the handshake
        data    = rdata;
        resp    = rresp;
        if (!rvalid) begin
            $display("read of offset %h got no data", addr);
            errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid || rdata !== data) begin
                $display("read data of %h changed before it was accepted", addr);
                errors++;
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // load operands, issue, read back and compare
    task automatic run_op(input control_e code, input operand_t a, input operand_t b,
                          output result_t got_r, output status_t got_s);
        result_t     exp_r;
        status_t     exp_s;
        axi_resp_e   resp;
        logic [31:0] word;
        model(code, a, b, exp_r, exp_s);
        axi_write(REG_A, {16'h0, a}, 0, resp);
        check_resp("bresp", OKAY, resp);
        axi_write(REG_B, {16'h0, b}, 0, resp);
        check_resp("bresp", OKAY, resp);
        axi_write(REG_CTRL, {28'h0, code}, 0, resp);
        check_resp("bresp", OKAY, resp);
        axi_read(REG_RESULT, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        got_r = word;
        check_result("result", exp_r, got_r);
        axi_read(REG_STATUS, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        got_s = word[3:0];
        check_status(exp_s, 1'b1, got_s, word[4]);
    endtask

    task automatic end_test(input string name);
        if (errors == test_start) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - test_start);
            tests_failed++;
        end
        test_start = errors;
    endtask

    task automatic test_reset;
        logic [31:0] word;
        axi_resp_e   resp;
        axi_read(REG_RESULT, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        check_result("result", '0, word);
        axi_read(REG_STATUS, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        check_status('0, 1'b0, word[3:0], word[4]);
        axi_read(REG_A, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        check_result("reg_a", '0, word);
        axi_read(REG_B, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        check_result("reg_b", '0, word);
        end_test("reset_state");
    endtask

    task automatic test_opcodes;
        result_t r;
        status_t s;
        run_op(OR, 16'h00F0, 16'h0F0F, r, s);
        run_op(AND, 16'hFF00, 16'h0FF0, r, s);
        run_op(MULT, 16'hFFFF, 16'hFFFF, r, s);    // sign from bit 31
        run_op(MULT, 16'h0012, 16'h0034, r, s);
        run_op(ROL, 16'h8001, 16'd17, r, s);
        run_op(ROR, 16'h0001, 16'd4, r, s);
        run_op(ROR, 16'h1234, 16'd17, r, s);
        run_op(SHL, 16'h00FF, 16'd16, r, s);
        run_op(SHL, 16'h00FF, 16'd4, r, s);
        run_op(SHR, 16'hF000, 16'd20, r, s);
        run_op(SUB, 16'h1234, 16'h1234, r, s);     // zero
        run_op(SUB, 16'h8000, 16'h0001, r, s);     // negative overflow
        run_op(ADD, 16'h7FFF, 16'h0001, r, s);     // positive overflow
        run_op(DIV, 16'h0064, 16'h0007, r, s);
        end_test("every_opcode");
    endtask

    task automatic test_divide;
        result_t     r;
        status_t     s;
        logic [31:0] word;
        axi_resp_e   resp;
        run_op(DIV, 16'h1234, 16'h0000, r, s);
        check_result("result", 32'h0, r);
        axi_read(REG_STATUS, 0, word, resp);
        check_resp("rresp", OKAY, resp);
        check_status(status_t'(4'b1100), 1'b1, word[3:0], word[4]);  // zero and div0
        run_op(DIV, 16'd100, 16'd7, r, s);
        check_result("result", {16'd2, 16'd14}, r);
        end_test("divide");
    endtask

    task automatic test_random;
        result_t  r;
        status_t  s;
        operand_t a;
        operand_t b;
        control_e code;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            a    = $random(seed);
            b    = $random(seed);
            code = control_e'({$random(seed)} % OP_COUNT);
            run_op(code, a, b, r, s);
        end
        end_test("random_ops");
    endtask

    task automatic test_errors;
        result_t     r;
        status_t     s;
        result_t     exp_r;
        status_t     exp_s;
        logic [31:0] word;
        axi_resp_e   resp;
        model(SUB, 16'h0005, 16'h0009, exp_r, exp_s);
        run_op(SUB, 16'h0005, 16'h0009, r, s);
        axi_write(REG_A, 32'h0100, 0, resp);  // a stray issue would now differ
        check_resp("bresp", OKAY, resp);
        axi_write(REG_CTRL, 32'd12, 0, resp);
        check_resp("bresp", SLVERR, resp);
        axi_read(REG_RESULT, 0, word, resp);
        check_result("result", exp_r, word);
        axi_read(REG_STATUS, 0, word, resp);
        check_status(exp_s, 1'b1, word[3:0], word[4]);
        axi_read(REG_CTRL, 0, word, resp);
        check_result("ctrl", {28'h0, SUB}, word);  // last legal opcode
        axi_write(REG_RESULT, 32'h0000DEAD, 0, resp);
        check_resp("bresp", SLVERR, resp);
        axi_write(8'h1C, 32'h1, 0, resp);
        check_resp("bresp", SLVERR, resp);
        axi_read(8'h1C, 0, word, resp);
        check_resp("rresp", SLVERR, resp);
        check_result("rdata", '0, word);
        end_test("error_responses");
    endtask

    task automatic test_hold;
        result_t     exp_r;
        status_t     exp_s;
        logic [31:0] word;
        axi_resp_e   resp;
        axi_write(REG_A, 32'h0300, 0, resp);
        axi_write(REG_B, 32'h0011, 0, resp);
        axi_write(REG_CTRL, {28'h0, MULT}, 5, resp);
        check_resp("bresp", OKAY, resp);
        model(MULT, 16'h0300, 16'h0011, exp_r, exp_s);
        axi_read(REG_RESULT, 4, word, resp);
        check_result("result", exp_r, word);
        axi_write(REG_A, 32'h0001, 0, resp);
        axi_read(REG_RESULT, 0, word, resp);
        check_result("result", exp_r, word);    // old value until next issue
        axi_write(REG_CTRL, {28'h0, MULT}, 0, resp);
        model(MULT, 16'h0001, 16'h0011, exp_r, exp_s);
        axi_read(REG_RESULT, 0, word, resp);
        check_result("result", exp_r, word);
        end_test("backpressure_hold");
    endtask

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        test_reset();
        test_opcodes();
        test_divide();
        test_random();
        test_errors();
        test_hold();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
alu_pkg.sv
alu_op_if.sv
alu_axi_decode.sv
alu.sv
alu_result.sv
alu_top.sv
tb_alu.sv

// ==== Bender.yml ====
package:
  name: alu_axi

sources:
  - alu_pkg.sv
  - alu_op_if.sv
  - alu_axi_decode.sv
  - alu.sv
  - alu_result.sv
  - alu_top.sv
  - target: test
    files:
      - tb_alu.sv
